// File: sources.f
+incdir+rtl
rtl/display_types_pkg.sv
rtl/host_if_pkg.sv
rtl/display_host_port.sv
rtl/seven_segment_decoder.sv
rtl/digit_scanner.sv
rtl/multi_digit_display.sv
dv/tb_clock_gen.sv
dv/display_checker.sv
dv/multi_digit_display_tb.sv

// File: dv/multi_digit_display_tb.sv
`timescale 1ns/1ps

`include "display_settings.svh"

module multi_digit_display_tb;

    import display_types_pkg::*;
    import host_if_pkg::*;

    localparam int FIXED_TESTS      = 12;
    localparam int NUM_TESTS        = 20;
    localparam int ROUND_CYCLES     = 4 * `SCAN_DIVIDE;
    localparam int HOLD_CYCLES      = 2 * ROUND_CYCLES;  // two full scan rounds
    localparam int HANDSHAKE_MARGIN = 24;
    localparam int ACK_LIMIT        = 8;
    localparam int RESET_CYCLES     = 8;
    localparam int CLOCK_NS         = 8;
    localparam int WATCHDOG_NS      =
        (NUM_TESTS * (HOLD_CYCLES + HANDSHAKE_MARGIN) + RESET_CYCLES + 4) * CLOCK_NS;

    typedef struct
    {
        logic [15:0] value;
        logic [3:0]  dots;
        logic        blank_zeros;
        logic [3:0]  blank_expect;  // digits that must stay dark
    } table_entry_t;

    logic           clock;
    logic           resetn;
    logic           req;
    logic           ack;
    write_request_t request;
    logic [3:0]     expected_blank;
    display_drive_t drive;
    table_entry_t   stimulus [NUM_TESTS];
    int             host_errors = 0;

    tb_clock_gen clock_gen
    (
        .clock  (clock),
        .resetn (resetn)
    );

    multi_digit_display UUT
    (
        .clock   (clock),
        .resetn  (resetn),
        .req     (req),
        .request (request),
        .ack     (ack),
        .drive   (drive)
    );

    display_checker checks
    (
        .clock          (clock),
        .resetn         (resetn),
        .req            (req),
        .request        (request),
        .expected_blank (expected_blank),
        .ack            (ack),
        .drive          (drive)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1103515245 + 32'd12345;
    endfunction

    // a digit above 0 goes dark when nothing nonzero sits at or above it
    function automatic logic [3:0] leading_blank(input logic [15:0] value, input logic blank);
        logic [3:0] mask;

        mask = '0;
        for (int i = 1; i < 4; i++)
            mask[i] = blank && ((value >> (4 * i)) == 16'h0);
        return mask;
    endfunction

    task automatic set_entry(input int index, input logic [15:0] value, input logic [3:0] dots,
                             input logic blank, input logic [3:0] blank_expect);
        stimulus[index].value        = value;
        stimulus[index].dots         = dots;
        stimulus[index].blank_zeros  = blank;
        stimulus[index].blank_expect = blank_expect;
    endtask

    task automatic fill_table();
        logic [31:0] state;
        logic [15:0] value;

        set_entry(0,  16'h0123, 4'b0001, 1'b0, 4'b0000);
        set_entry(1,  16'h4567, 4'b0010, 1'b0, 4'b0000);
        set_entry(2,  16'h89ab, 4'b0100, 1'b1, 4'b0000);
        set_entry(3,  16'hcdef, 4'b1000, 1'b1, 4'b0000);
        set_entry(4,  16'h0123, 4'b1111, 1'b1, 4'b1000);  // dot 3 hidden
        set_entry(5,  16'h0000, 4'b0101, 1'b0, 4'b0000);
        set_entry(6,  16'h0000, 4'b1111, 1'b1, 4'b1110);  // only digit 0 lit
        set_entry(7,  16'h00a5, 4'b1010, 1'b1, 4'b1100);
        set_entry(8,  16'h0007, 4'b0000, 1'b1, 4'b1110);
        set_entry(9,  16'h0300, 4'b0011, 1'b1, 4'b1000);
        set_entry(10, 16'h0f00, 4'b1001, 1'b0, 4'b0000);
        set_entry(11, 16'h0040, 4'b0110, 1'b1, 4'b1100);

        state = 32'h40f6;
        for (int i = FIXED_TESTS; i < NUM_TESTS; i++)
        begin
            state = lcg_next(state);
            value = state[31:16] >> (4 * state[13:12]);  // leading zeros now and then
            set_entry(i, value, state[7:4], state[8], leading_blank(value, state[8]));
        end
    endtask

    task automatic wait_ack(input logic level, input int test_no);
        int waited;

        waited = 0;
        while (ack !== level && waited < ACK_LIMIT)
        begin
            @(negedge clock);
            waited++;
        end
        if (ack !== level)
        begin
            $display("test %0d: ack did not go to %0d within %0d cycles of req", test_no,
                     level, ACK_LIMIT);
            host_errors++;
        end
    endtask

    // one four-phase write, then let the display run
    task automatic write_display(input int index);
        @(negedge clock);
        request.value       = stimulus[index].value;
        request.dots        = stimulus[index].dots;
        request.blank_zeros = stimulus[index].blank_zeros;
        expected_blank      = stimulus[index].blank_expect;
        @(negedge clock);
        req = 1'b1;
        wait_ack(1'b1, index);
        repeat (index % 3) @(negedge clock);  // slow host keeps req up a little longer
        req = 1'b0;
        wait_ack(1'b0, index);
        repeat (HOLD_CYCLES) @(negedge clock);
        checks.close_test(index);
    endtask

    initial
    begin
        req            = 1'b0;
        request        = '0;
        expected_blank = '0;
        fill_table();
        wait (resetn === 1'b1);

        for (int i = 0; i < NUM_TESTS; i++)
            write_display(i);

        $display("tests %0d, tests with errors %0d, value errors %0d, handshake errors %0d",
                 checks.tests_done, checks.tests_failed, checks.error_count, host_errors);
        if (checks.error_count == 0 && host_errors == 0)
            $display("*** PASSED ***");
        else
            $display("*** FAILED ***");
        $finish;
    end

    initial
    begin
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns, the run did not finish", WATCHDOG_NS);
        $display("*** FAILED ***");
        $finish;
    end

endmodule

// File: dv/display_checker.sv
`timescale 1ns/1ps

`include "display_settings.svh"

module display_checker
(
    input logic                              clock,
    input logic                              resetn,
    input logic                              req,
    input host_if_pkg::write_request_t       request,
    input logic [3:0]                        expected_blank,
    input logic                              ack,
    input display_types_pkg::display_drive_t drive
);

    import display_types_pkg::*;
    import host_if_pkg::*;

    localparam display_drive_t DRIVE_OFF = {`SEGMENTS_OFF, 1'b1, `ANODES_OFF};

    int             error_count   = 0;
    int             tests_done    = 0;
    int             tests_failed  = 0;
    int             test_errors   = 0;
    int             edge_count    = 0;  // clock edges since reset release
    logic           seen_reset    = 1'b0;
    logic           model_ack     = 1'b0;
    write_request_t model_request = '0;
    logic [3:0]     model_blank   = '0;  // digits expected dark
    display_drive_t model_drive   = DRIVE_OFF;

    // common-anode hex codes as the panel expects them
    function automatic segments_t hex_segments(input hex_digit_t value);
        case (value)
            4'h0: return 7'h01;
            4'h1: return 7'h4f;
            4'h2: return 7'h12;
            4'h3: return 7'h06;
            4'h4: return 7'h4c;
            4'h5: return 7'h24;
            4'h6: return 7'h20;
            4'h7: return 7'h0f;
            4'h8: return 7'h00;
            4'h9: return 7'h0c;
            4'ha: return 7'h08;
            4'hb: return 7'h60;
            4'hc: return 7'h31;
            4'hd: return 7'h42;
            4'he: return 7'h30;
            default: return 7'h38;
        endcase
    endfunction

    function automatic display_drive_t slot_drive(input write_request_t r,
                                                  input logic [3:0] blank, input int slot);
        display_drive_t d;

        if (blank[slot])
            return DRIVE_OFF;  // dark slot, dot ignored
        d.segments     = hex_segments(r.value[slot*4 +: 4]);
        d.dot          = !r.dots[slot];
        d.anodes       = 4'b1111;
        d.anodes[slot] = 1'b0;
        return d;
    endfunction

    task automatic compare(input string name, input logic [11:0] expected,
                           input logic [11:0] actual);
        if (actual !== expected)
        begin
            $display("ERR t=%0t %s expected %h actual %h", $time, name, expected, actual);
            error_count++;
            test_errors++;
        end
    endtask

    // called by the testbench once a test's hold time is over
    task automatic close_test(input int number);
        tests_done++;
        if (test_errors == 0)
        begin
            $display("test %0d value %h dots %b blank %b ok", number, model_request.value,
                     model_request.dots, model_request.blank_zeros);
        end
        else
        begin
            tests_failed++;
            $display("test %0d value %h dots %b blank %b had %0d errors", number,
                     model_request.value, model_request.dots, model_request.blank_zeros,
                     test_errors);
        end
    endtask

    // values seen here are the ones held during the cycle that just ended
    always @(posedge clock)
    begin
        if (seen_reset)
        begin
            compare("ack", model_ack, ack);
            compare("drive.segments", model_drive.segments, drive.segments);
            compare("drive.dot", model_drive.dot, drive.dot);
            compare("drive.anodes", model_drive.anodes, drive.anodes);
        end

        if (!resetn)
        begin
            seen_reset    = 1'b1;
            edge_count    = 0;
            model_ack     = 1'b0;
            model_request = '0;
            model_blank   = '0;
            model_drive   = DRIVE_OFF;
        end
        else
        begin
            edge_count++;
            if (edge_count % `SCAN_DIVIDE == 0)  // slot boundary
                model_drive = slot_drive(model_request, model_blank,
                                         ((edge_count / `SCAN_DIVIDE) - 1) % 4);
            if (!model_ack && req)
            begin
                model_ack     = 1'b1;  // ack rises on this edge
                model_request = request;
                model_blank   = expected_blank;
                test_errors   = 0;
            end
            else if (model_ack && !req)
            begin
                model_ack = 1'b0;
            end
        end
    end

endmodule

// File: dv/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen
(
    output logic clock,
    output logic resetn
);

    initial
    begin
        clock  = 1'b0;
        resetn = 1'b0;
        repeat (8) @(posedge clock);
        @(negedge clock);
        resetn = 1'b1;  // released between sampling edges
    end

    always #4 clock = ~clock;  // 8 ns period

endmodule

// File: rtl/multi_digit_display.sv
`timescale 1ns/1ps

module multi_digit_display
(
    input  logic                              clock,
    input  logic                              resetn,
    input  logic                              req,
    input  host_if_pkg::write_request_t       request,
    output logic                              ack,
    output display_types_pkg::display_drive_t drive
);

    import display_types_pkg::*;
    import host_if_pkg::*;

    write_request_t current_request;  // held copy of the last write
    hex_digit_t     digit;
    segments_t      pattern;

    display_host_port host_port
    (
        .clock           (clock),
        .resetn          (resetn),
        .req             (req),
        .request         (request),
        .ack             (ack),
        .current_request (current_request)
    );

    digit_scanner scanner
    (
        .clock           (clock),
        .resetn          (resetn),
        .current_request (current_request),
        .pattern         (pattern),
        .digit           (digit),
        .drive           (drive)
    );

    // table lookup for the scanner's next digit
    seven_segment_decoder decoder
    (
        .digit           (digit),
        .pattern         (pattern)
    );

endmodule

// File: rtl/digit_scanner.sv
`timescale 1ns/1ps

`include "display_settings.svh"

module digit_scanner
(
    input  logic                              clock,
    input  logic                              resetn,
    input  host_if_pkg::write_request_t       current_request,
    input  display_types_pkg::segments_t      pattern,
    output display_types_pkg::hex_digit_t     digit,
    output display_types_pkg::display_drive_t drive
);

    import display_types_pkg::*;

    localparam int COUNT_WIDTH = $clog2(`SCAN_DIVIDE);
    localparam logic [COUNT_WIDTH-1:0] LAST_COUNT = COUNT_WIDTH'(`SCAN_DIVIDE - 1);

    localparam display_drive_t DRIVE_OFF = '{
        segments: `SEGMENTS_OFF,
        dot:      1'b1,
        anodes:   `ANODES_OFF
    };

    logic [COUNT_WIDTH-1:0] scan_count;
    logic                   tick;
    digit_index_t           next_index;   // digit loaded on the coming tick
    logic [3:0]             blank_mask;   // bit i set when digit i is blanked
    logic                   slot_blank;
    anode_mask_t            slot_anodes;

    // prescaler, first tick lands SCAN_DIVIDE cycles after reset release
    always_ff @(posedge clock or negedge resetn)
    begin
        if (!resetn)
            scan_count <= '0;
        else if (tick)
            scan_count <= '0;
        else
            scan_count <= scan_count + 1'b1;
    end

    assign tick = (scan_count == LAST_COUNT);

    always_ff @(posedge clock or negedge resetn)
    begin
        if (!resetn)
            next_index <= '0;
        else if (tick)
            next_index <= next_index + 1'b1;  // wraps 3 to 0
    end

    // nibble for the decoder, pattern comes back in the same cycle
    assign digit = current_request.value[{next_index, 2'b00} +: 4];

    // Walk down from the top nibble. A digit is blank while it and
    // everything above it are zero, but digit 0 always shows.
    always_comb
    begin : leading_zero_blank
        logic upper_zero;

        upper_zero = 1'b1;
        for (int i = 3; i >= 0; i--)
        begin
            upper_zero    = upper_zero && (current_request.value[i*4 +: 4] == 4'h0);
            blank_mask[i] = current_request.blank_zeros && upper_zero && (i != 0);
        end
    end

    assign slot_blank  = blank_mask[next_index];
    assign slot_anodes = ~(anode_mask_t'(1) << next_index);  // one low bit

    // the lit slot is only ever replaced on a tick, never mid-slot
    always_ff @(posedge clock or negedge resetn)
    begin
        if (!resetn)
        begin
            drive <= DRIVE_OFF;
        end
        else if (tick)
        begin
            if (slot_blank)
            begin
                drive <= DRIVE_OFF;  // dot forced dark too
            end
            else
            begin
                drive.segments <= pattern;
                drive.dot      <= ~current_request.dots[next_index];
                drive.anodes   <= slot_anodes;
            end
        end
    end

endmodule

// File: rtl/seven_segment_decoder.sv
`timescale 1ns/1ps

module seven_segment_decoder
(
    input  display_types_pkg::hex_digit_t digit,
    output display_types_pkg::segments_t  pattern
);

    // Segment layout, bit 6 is a and bit 0 is g:
    //
    //      a
    //    f   b
    //      g
    //    e   c
    //      d
    //
    // a zero bit lights the segment

    always_comb
    begin
        case (digit)
            4'h0: pattern = 7'b000_0001;  // g dark
            4'h1: pattern = 7'b100_1111;  // b c
            4'h2: pattern = 7'b001_0010;
            4'h3: pattern = 7'b000_0110;
            4'h4: pattern = 7'b100_1100;
            4'h5: pattern = 7'b010_0100;
            4'h6: pattern = 7'b010_0000;
            4'h7: pattern = 7'b000_1111;  // a b c
            4'h8: pattern = 7'b000_0000;  // all lit
            4'h9: pattern = 7'b000_1100;
            4'ha: pattern = 7'b000_1000;
            4'hb: pattern = 7'b110_0000;  // lower case b
            4'hc: pattern = 7'b011_0001;
            4'hd: pattern = 7'b100_0010;  // lower case d
            4'he: pattern = 7'b011_0000;
            4'hf: pattern = 7'b011_1000;
            default: pattern = 7'b111_1111;
        endcase
    end

endmodule

// File: rtl/display_host_port.sv
`timescale 1ns/1ps

module display_host_port
(
    input  logic                        clock,
    input  logic                        resetn,
    input  logic                        req,
    input  host_if_pkg::write_request_t request,
    output logic                        ack,
    output host_if_pkg::write_request_t current_request
);

    import host_if_pkg::*;

    host_port_state_t state;
    host_port_state_t next_state;
    logic             capture;

    // request is sampled only once per handshake, on the edge that leaves IDLE
    assign capture = (state == IDLE) && req;

    always_comb
    begin
        next_state = state;

        case (state)
            IDLE:
                if (req)
                    next_state = ACK_HIGH;

            ACK_HIGH:
                if (req)
                    next_state = WAIT_REQ_LOW;
                else
                    next_state = IDLE;  // host already let go

            WAIT_REQ_LOW:
                if (!req)
                    next_state = IDLE;

            default:
                next_state = IDLE;
        endcase
    end

    always_ff @(posedge clock or negedge resetn)
    begin
        if (!resetn)
            state <= IDLE;
        else
            state <= next_state;
    end

    // ack comes straight from the state register, so it is glitch free
    assign ack = (state != IDLE);

    // holding the request frees the host bus once the handshake completes
    always_ff @(posedge clock or negedge resetn)
    begin
        if (!resetn)
            current_request <= '0;
        else if (capture)
            current_request <= request;
    end

endmodule

// File: rtl/host_if_pkg.sv
package host_if_pkg;

    // one display write from the host, held stable while req is high
    typedef struct packed
    {
        display_types_pkg::display_value_t value;
        logic [3:0]                        dots;         // active high, bit i for digit i
        logic                              blank_zeros;  // hide leading zero digits
    } write_request_t;

    // four-phase receiver states
    typedef enum logic [1:0]
    {
        IDLE,          // ack low, waiting for req
        ACK_HIGH,      // first cycle with ack up
        WAIT_REQ_LOW   // ack held until host drops req
    } host_port_state_t;

endpackage

// File: rtl/display_types_pkg.sv
package display_types_pkg;

    typedef logic [3:0]  hex_digit_t;      // one hex nibble
    typedef logic [6:0]  segments_t;       // a in bit 6, g in bit 0, active low
    typedef logic [1:0]  digit_index_t;    // which of the four digits
    typedef logic [3:0]  anode_mask_t;     // one enable per digit, active low
    typedef logic [15:0] display_value_t;  // digit 0 in the low nibble

    // everything the panel pins see in one slot
    typedef struct packed
    {
        segments_t   segments;
        logic        dot;                  // active low
        anode_mask_t anodes;
    } display_drive_t;

endpackage

// File: rtl/display_settings.svh
`ifndef DISPLAY_SETTINGS_SVH
`define DISPLAY_SETTINGS_SVH

// clock cycles each digit stays selected, must be 2 or more
`define SCAN_DIVIDE  4

// segments, dot and anodes are all active low on a common-anode display
`define SEGMENTS_OFF 7'b111_1111  // a to g dark
`define ANODES_OFF   4'b1111      // no digit selected

`endif
